/* design/rx_link_pkg.sv */
// Receive link constants: line symbols, frame head flag and parser state codes
`default_nettype none

package rx_link_pkg;

    // Width of one word on the serial lane
    localparam int LINE_W = 16;

    ////////////////////////////////////////
    // Line symbols
    ////////////////////////////////////////

    // Sync word is {D5_6, K28_5}, only the low K flag set
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;

    // Start of frame is {K28_2, K27_7}, both K flags set
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;

    // Two head words that follow the start of frame
    localparam logic [31:0] FRAME_HEAD_FLAG = 32'hEB90_E116;

    // All ones with both K flags means the far end lost the link
    localparam logic [LINE_W-1:0] LINK_DOWN_WORD = 16'hFFFF;

    ////////////////////////////////////////
    // Parser states
    ////////////////////////////////////////

    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_SYNC  = 4'd1;
    localparam logic [3:0] ST_HEAD  = 4'd2;
    localparam logic [3:0] ST_TYPE  = 4'd3;
    localparam logic [3:0] ST_LINE  = 4'd4;
    localparam logic [3:0] ST_LEN   = 4'd5;
    localparam logic [3:0] ST_DATA  = 4'd6;
    localparam logic [3:0] ST_CHECK = 4'd7;
    localparam logic [3:0] ST_END1  = 4'd8;
    localparam logic [3:0] ST_END2  = 4'd9;

endpackage

`default_nettype wire

/* design/rx_frame_if.sv */
// Payload word, length and frame end strobes from the parser to its consumers
`timescale 1ns/100ps
`default_nettype none

interface rx_frame_if
    import rx_link_pkg::*;
();

    // Plain strobes, every consumer takes each one as it comes
    logic              word_valid;
    logic [LINE_W-1:0] word;
    logic              len_valid;
    logic [LINE_W-1:0] frame_length;
    logic              frame_end;

    modport src  (output word_valid, word, len_valid, frame_length, frame_end);

    modport pack (input word_valid, word, frame_end);

    modport cmd  (input len_valid, frame_length, frame_end);

endinterface

`default_nettype wire

/* design/rx_frame_parser.sv */
// Frame parser: sync and head search, header capture, checksum and line event flags
`timescale 1ns/100ps
`default_nettype none

module rx_frame_parser
    import rx_link_pkg::*;
(
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_rkmsb,
    input  logic              i_rklsb,
    input  logic [LINE_W-1:0] i_rxd,
    rx_frame_if.src           frame,
    output logic [3:0]        o_rx_data_type,
    output logic [1:0]        o_rx_channel_id,
    output logic              o_rx_file_end_flag,
    output logic [23:0]       o_rx_frame_num,
    output logic              o_rx_checksum_flag,
    output logic              o_link_down_evt,
    output logic              o_sync_err_evt
);

    logic [3:0]        cs;
    logic [3:0]        ns;
    logic [LINE_W-1:0] rxd_d;
    logic [LINE_W-2:0] data_cnt;
    logic [LINE_W-1:0] len_q;
    logic [LINE_W-1:0] checksum;
    logic              in_frame;

    // Header fields as they arrive, published at the checksum word
    logic              hdr_file_end;
    logic [1:0]        hdr_channel;
    logic [3:0]        hdr_type;
    logic [23:0]       hdr_num;

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cs <= ST_IDLE;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            ST_IDLE: begin
                if (!i_rkmsb && i_rklsb && (i_rxd == {D5_6, K28_5})) begin
                    ns = ST_SYNC;
                end
            end
            ST_SYNC: begin
                if (i_rkmsb && i_rklsb && (i_rxd == {K28_2, K27_7})) begin
                    ns = ST_HEAD;
                end
            end
            // Head flag spans the previous and the current word
            ST_HEAD: begin
                if ({rxd_d, i_rxd} == FRAME_HEAD_FLAG) begin
                    ns = ST_TYPE;
                end
            end
            ST_TYPE:  ns = ST_LINE;
            ST_LINE:  ns = ST_LEN;
            ST_LEN:   ns = ST_DATA;
            // Length is in bytes, two bytes per word
            ST_DATA: begin
                if (data_cnt == len_q[LINE_W-1:1] - 1'b1) begin
                    ns = ST_CHECK;
                end
            end
            ST_CHECK: ns = ST_END1;
            ST_END1:  ns = ST_END2;
            default:  ns = ST_IDLE;
        endcase
    end

    // Delayed word, also the payload word seen by the packer
    always_ff @(posedge clk) begin
        rxd_d <= i_rxd;
    end

    assign frame.word = rxd_d;
    assign frame.frame_length = len_q;

    ////////////////////////////////////////
    // Strobes, length and word count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            frame.word_valid <= 1'b0;
            frame.len_valid  <= 1'b0;
            frame.frame_end  <= 1'b0;
            len_q            <= '0;
            data_cnt         <= '0;
        end else begin
            frame.word_valid <= (cs == ST_DATA);
            frame.len_valid  <= (cs == ST_LEN);
            frame.frame_end  <= (cs == ST_CHECK);
            if (cs == ST_LEN) begin
                len_q <= i_rxd;
            end
            if (cs == ST_DATA) begin
                data_cnt <= data_cnt + 1'b1;
            end else begin
                data_cnt <= '0;
            end
        end
    end

    // Sum covers type, line, length and payload words
    always_ff @(posedge clk) begin
        if (i_rst) begin
            checksum           <= '0;
            o_rx_checksum_flag <= 1'b0;
        end else begin
            case (cs)
                ST_TYPE, ST_LINE, ST_LEN, ST_DATA: begin
                    checksum <= checksum + i_rxd;
                end
                ST_CHECK: begin
                    o_rx_checksum_flag <= (checksum != i_rxd);
                end
                default: begin
                    checksum <= '0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Header fields
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cs == ST_TYPE) begin
            hdr_file_end   <= i_rxd[14];
            hdr_channel    <= i_rxd[13:12];
            hdr_type       <= i_rxd[11:8];
            hdr_num[23:16] <= i_rxd[7:0];
        end
        if (cs == ST_LINE) begin
            hdr_num[15:0] <= i_rxd;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_rx_file_end_flag <= 1'b0;
            o_rx_channel_id    <= '0;
            o_rx_data_type     <= '0;
            o_rx_frame_num     <= '0;
        end else if (cs == ST_CHECK) begin
            o_rx_file_end_flag <= hdr_file_end;
            o_rx_channel_id    <= hdr_channel;
            o_rx_data_type     <= hdr_type;
            o_rx_frame_num     <= hdr_num;
        end
    end

    // Line events, registered by the loss detectors
    assign in_frame = (cs >= ST_TYPE) && (cs <= ST_CHECK);
    assign o_link_down_evt = i_rkmsb && i_rklsb && (i_rxd == LINK_DOWN_WORD);
    assign o_sync_err_evt = (i_rkmsb || i_rklsb) && in_frame;

endmodule

`default_nettype wire

/* design/rx_word_packer.sv */
// Word packer: four payload words per 64-bit entry, zero padded at frame end, FIFO to DMA
`timescale 1ns/100ps
`default_nettype none

module rx_word_packer
    import rx_link_pkg::*;
#(
    parameter int FIFO_DEPTH = 512
) (
    input  logic        clk,
    input  logic        i_rst,
    rx_frame_if.pack    frame,
    input  logic        i_dma_wr_ready,
    output logic        o_dma_wr_valid,
    output logic [63:0] o_dma_wr_data
);

    // FIFO_DEPTH is expected to be a power of two
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [3*LINE_W-1:0] group;
    logic [1:0]          lane_cnt;
    logic                push;
    logic [63:0]         push_data;

    logic [63:0]         mem [FIFO_DEPTH];
    logic [PTR_W:0]      wr_ptr;
    logic [PTR_W:0]      rd_ptr;
    logic                fifo_empty;
    logic                fifo_full;

    ////////////////////////////////////////
    // Lane packing
    ////////////////////////////////////////

    // Older words shift up so the first word ends in the top lane
    always_ff @(posedge clk) begin
        if (frame.word_valid) begin
            group <= {group[2*LINE_W-1:0], frame.word};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            lane_cnt <= '0;
        end else if (frame.word_valid) begin
            lane_cnt <= lane_cnt + 1'b1;
        end else if (frame.frame_end) begin
            lane_cnt <= '0;
        end
    end

    always_comb begin
        push      = 1'b0;
        push_data = {group, frame.word};
        if (frame.word_valid) begin
            push = (lane_cnt == 2'd3);
        end else if (frame.frame_end) begin
            // Partial group, fill the low lanes with zeros
            push = (lane_cnt != 2'd0);
            case (lane_cnt)
                2'd1:    push_data = {group[LINE_W-1:0], {(3*LINE_W){1'b0}}};
                2'd2:    push_data = {group[2*LINE_W-1:0], {(2*LINE_W){1'b0}}};
                default: push_data = {group, {LINE_W{1'b0}}};
            endcase
        end
    end

    ////////////////////////////////////////
    // FIFO
    ////////////////////////////////////////

    // Extra pointer bit tells full from empty
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // Line cannot stall, a push into a full FIFO is lost
    always_ff @(posedge clk) begin
        if (push && !fifo_full) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !fifo_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (o_dma_wr_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // First word fall through, each valid cycle takes one entry
    assign o_dma_wr_valid = !fifo_empty && i_dma_wr_ready;
    assign o_dma_wr_data  = mem[rd_ptr[PTR_W-1:0]];

endmodule

`default_nettype wire

/* design/dma_cmd_gen.sv */
// DMA write command: rounded byte count, request until ack, running write address
`timescale 1ns/100ps
`default_nettype none

module dma_cmd_gen
    import rx_link_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DLEN_WIDTH = 16
) (
    input  logic                             clk,
    input  logic                             i_rst,
    rx_frame_if.cmd                          frame,
    input  logic                             i_rx_start,
    input  logic [ADDR_WIDTH-1:0]            i_rx_base_addr,
    input  logic                             i_wr_cmd_ack,
    output logic                             o_wr_cmd_req,
    output logic [ADDR_WIDTH+DLEN_WIDTH-1:0] o_wr_cmd_data
);

    logic [LINE_W:0]       len_up;
    logic [DLEN_WIDTH-1:0] round_len;
    logic [DLEN_WIDTH-1:0] wr_bbt;
    logic [ADDR_WIDTH-1:0] wr_addr;

    // DDR writes go in 8-byte units, so round the byte count up
    assign len_up    = {1'b0, frame.frame_length} + (LINE_W+1)'(7);
    assign round_len = DLEN_WIDTH'({len_up[LINE_W:3], 3'b000});

    always_ff @(posedge clk) begin
        if (frame.len_valid) begin
            wr_bbt <= round_len;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr_cmd_req <= 1'b0;
        end else if (frame.len_valid) begin
            o_wr_cmd_req <= 1'b1;
        end else if (i_wr_cmd_ack) begin
            o_wr_cmd_req <= 1'b0;
        end
    end

    // Next frame lands right after this one
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_addr <= '0;
        end else if (i_rx_start) begin
            wr_addr <= i_rx_base_addr;
        end else if (frame.frame_end) begin
            wr_addr <= wr_addr + ADDR_WIDTH'(wr_bbt);
        end
    end

    assign o_wr_cmd_data = {wr_addr, wr_bbt};

endmodule

`default_nettype wire

/* design/loss_holdoff.sv */
// Loss detector: one pulse per line event, then a holdoff before the next
`timescale 1ns/100ps
`default_nettype none

module loss_holdoff #(
    parameter int HOLDOFF_CYCLES = 10_000_000
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_ena,
    input  logic i_event,
    output logic o_loss
);

    localparam int CNT_W = $clog2(HOLDOFF_CYCLES + 1);

    logic             holdoff;
    logic [CNT_W-1:0] hold_cnt;

    // Keeps the host from being flooded while the line stays bad
    always_ff @(posedge clk) begin
        if (i_rst || !i_ena) begin
            o_loss   <= 1'b0;
            holdoff  <= 1'b0;
            hold_cnt <= '0;
        end else begin
            // Pulse is one cycle even when the event persists
            o_loss <= i_event && !holdoff && !o_loss;

            if (o_loss) begin
                holdoff <= 1'b1;
            end else if (holdoff && (hold_cnt == CNT_W'(HOLDOFF_CYCLES - 1))) begin
                holdoff <= 1'b0;
            end

            if (holdoff && (hold_cnt != CNT_W'(HOLDOFF_CYCLES - 1))) begin
                hold_cnt <= hold_cnt + 1'b1;
            end else begin
                hold_cnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/tlk2711_rx_top.sv */
// Receive link top: frame parser, word packer, DMA command and link/sync loss detectors
`timescale 1ns/100ps
`default_nettype none

module tlk2711_rx_top #(
    parameter int ADDR_WIDTH     = 32,
    parameter int DLEN_WIDTH     = 16,
    parameter int FIFO_DEPTH     = 512,
    parameter int HOLDOFF_CYCLES = 10_000_000
) (
    input  logic                             clk,
    input  logic                             i_rst,
    // Lane from the transceiver
    input  logic                             i_2711_rkmsb,
    input  logic                             i_2711_rklsb,
    input  logic [15:0]                      i_2711_rxd,
    // DMA command
    input  logic                             i_rx_start,
    input  logic [ADDR_WIDTH-1:0]            i_rx_base_addr,
    input  logic                             i_wr_cmd_ack,
    output logic                             o_wr_cmd_req,
    output logic [ADDR_WIDTH+DLEN_WIDTH-1:0] o_wr_cmd_data,
    // DMA data
    input  logic                             i_dma_wr_ready,
    output logic                             o_dma_wr_valid,
    output logic [63:0]                      o_dma_wr_data,
    // Frame header
    output logic [3:0]                       o_rx_data_type,
    output logic [1:0]                       o_rx_channel_id,
    output logic                             o_rx_file_end_flag,
    output logic [23:0]                      o_rx_frame_num,
    output logic [15:0]                      o_rx_frame_length,
    output logic                             o_rx_checksum_flag,
    // Loss reporting
    input  logic                             i_link_loss_detect_ena,
    input  logic                             i_sync_loss_detect_ena,
    output logic                             o_link_loss,
    output logic                             o_sync_loss,
    output logic                             o_loss_interrupt
);

    rx_frame_if frame ();

    logic link_down_evt;
    logic sync_err_evt;

    rx_frame_parser u_parser (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_rkmsb            (i_2711_rkmsb),
        .i_rklsb            (i_2711_rklsb),
        .i_rxd              (i_2711_rxd),
        .frame              (frame.src),
        .o_rx_data_type     (o_rx_data_type),
        .o_rx_channel_id    (o_rx_channel_id),
        .o_rx_file_end_flag (o_rx_file_end_flag),
        .o_rx_frame_num     (o_rx_frame_num),
        .o_rx_checksum_flag (o_rx_checksum_flag),
        .o_link_down_evt    (link_down_evt),
        .o_sync_err_evt     (sync_err_evt)
    );

    rx_word_packer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_packer (
        .clk            (clk),
        .i_rst          (i_rst),
        .frame          (frame.pack),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dma_wr_data  (o_dma_wr_data)
    );

    dma_cmd_gen #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DLEN_WIDTH (DLEN_WIDTH)
    ) u_cmd (
        .clk            (clk),
        .i_rst          (i_rst),
        .frame          (frame.cmd),
        .i_rx_start     (i_rx_start),
        .i_rx_base_addr (i_rx_base_addr),
        .i_wr_cmd_ack   (i_wr_cmd_ack),
        .o_wr_cmd_req   (o_wr_cmd_req),
        .o_wr_cmd_data  (o_wr_cmd_data)
    );

    ////////////////////////////////////////
    // Loss detectors
    ////////////////////////////////////////

    loss_holdoff #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_link_loss (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_ena   (i_link_loss_detect_ena),
        .i_event (link_down_evt),
        .o_loss  (o_link_loss)
    );

    loss_holdoff #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_sync_loss (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_ena   (i_sync_loss_detect_ena),
        .i_event (sync_err_evt),
        .o_loss  (o_sync_loss)
    );

    assign o_loss_interrupt  = o_link_loss | o_sync_loss;
    assign o_rx_frame_length = frame.frame_length;

endmodule

`default_nettype wire

/* verif/tb_rx_link.sv */
// Testbench for the receive link with a frame driver, a DMA word and command model and loss checks
`timescale 1ns/100ps
`default_nettype none

module tb_rx_link;

    localparam int ADDR_WIDTH     = 32;
    localparam int DLEN_WIDTH     = 16;
    localparam int HOLDOFF_CYCLES = 40;
    // Tests take under 400 cycles
    localparam int MAX_CYCLES     = 3000;

    logic                             clk;
    logic                             i_rst;
    logic                             i_2711_rkmsb;
    logic                             i_2711_rklsb;
    logic [15:0]                      i_2711_rxd;
    logic                             i_rx_start;
    logic [ADDR_WIDTH-1:0]            i_rx_base_addr;
    logic                             i_wr_cmd_ack;
    logic                             o_wr_cmd_req;
    logic [ADDR_WIDTH+DLEN_WIDTH-1:0] o_wr_cmd_data;
    logic                             i_dma_wr_ready;
    logic                             o_dma_wr_valid;
    logic [63:0]                      o_dma_wr_data;
    logic [3:0]                       o_rx_data_type;
    logic [1:0]                       o_rx_channel_id;
    logic                             o_rx_file_end_flag;
    logic [23:0]                      o_rx_frame_num;
    logic [15:0]                      o_rx_frame_length;
    logic                             o_rx_checksum_flag;
    logic                             i_link_loss_detect_ena;
    logic                             i_sync_loss_detect_ena;
    logic                             o_link_loss;
    logic                             o_sync_loss;
    logic                             o_loss_interrupt;

    // Reference model state
    logic [63:0]                      exp_dma [0:63];
    int                               exp_wr = 0;
    int                               exp_rd = 0;
    logic [63:0]                      dma_expect;
    logic [ADDR_WIDTH-1:0]            exp_addr = '0;
    logic [DLEN_WIDTH-1:0]            exp_len = '0;
    logic [ADDR_WIDTH+DLEN_WIDTH-1:0] cmd_expect;

    int seed        = 57;
    int ack_wait    = 0;
    int ack_count   = 0;
    int frames_sent = 0;
    int link_pulses = 0;
    int sync_pulses = 0;
    int intr_pulses = 0;
    int cycle_cnt   = 0;

    tlk2711_rx_top #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DLEN_WIDTH     (DLEN_WIDTH),
        .FIFO_DEPTH     (512),
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) DUT (
        .clk                    (clk),
        .i_rst                  (i_rst),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_rx_start             (i_rx_start),
        .i_rx_base_addr         (i_rx_base_addr),
        .i_wr_cmd_ack           (i_wr_cmd_ack),
        .o_wr_cmd_req           (o_wr_cmd_req),
        .o_wr_cmd_data          (o_wr_cmd_data),
        .i_dma_wr_ready         (i_dma_wr_ready),
        .o_dma_wr_valid         (o_dma_wr_valid),
        .o_dma_wr_data          (o_dma_wr_data),
        .o_rx_data_type         (o_rx_data_type),
        .o_rx_channel_id        (o_rx_channel_id),
        .o_rx_file_end_flag     (o_rx_file_end_flag),
        .o_rx_frame_num         (o_rx_frame_num),
        .o_rx_frame_length      (o_rx_frame_length),
        .o_rx_checksum_flag     (o_rx_checksum_flag),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss),
        .o_loss_interrupt       (o_loss_interrupt)
    );

    always #10 clk = ~clk;

    assign dma_expect = exp_dma[exp_rd];
    assign cmd_expect = {exp_addr, exp_len};

    ////////////////////////////////////////
    // Monitors and ack responder
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (o_dma_wr_valid) begin
            exp_rd <= exp_rd + 1;
        end
        if (o_link_loss) begin
            link_pulses <= link_pulses + 1;
        end
        if (o_sync_loss) begin
            sync_pulses <= sync_pulses + 1;
        end
        if (o_loss_interrupt) begin
            intr_pulses <= intr_pulses + 1;
        end
    end

    // One-cycle ack three cycles after the request is seen
    always @(posedge clk) begin
        #2;
        if (i_rst || !o_wr_cmd_req || i_wr_cmd_ack) begin
            i_wr_cmd_ack = 1'b0;
            ack_wait     = 0;
        end else if (ack_wait == 2) begin
            i_wr_cmd_ack = 1'b1;
            ack_count    = ack_count + 1;
        end else begin
            ack_wait = ack_wait + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Concurrent checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (i_rst) o_dma_wr_valid |-> (exp_rd < exp_wr))
    else begin
        $display("DMA write at %0t when the model expected no more words", $time);
        $display("Finished with errors");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (i_rst)
        (o_dma_wr_valid && (exp_rd < exp_wr)) |-> (o_dma_wr_data == dma_expect))
    else begin
        $display("[ERROR] %0t o_dma_wr_data: got %h, expected %h",
                 $time, $sampled(o_dma_wr_data), $sampled(dma_expect));
        $display("Finished with errors");
        $fatal(1);
    end

    // Words must wait in the FIFO while the port is not ready
    assert property (@(posedge clk) disable iff (i_rst) !i_dma_wr_ready |-> !o_dma_wr_valid)
    else begin
        $display("[ERROR] %0t o_dma_wr_valid: got %b, expected 0",
                 $time, $sampled(o_dma_wr_valid));
        $display("Finished with errors");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_wr_cmd_req) |-> (o_wr_cmd_data == cmd_expect))
    else begin
        $display("[ERROR] %0t o_wr_cmd_data: got %h, expected %h",
                 $time, $sampled(o_wr_cmd_data), $sampled(cmd_expect));
        $display("Finished with errors");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (i_rst)
        (o_wr_cmd_req && !i_wr_cmd_ack) |=> o_wr_cmd_req)
    else begin
        $display("[ERROR] %0t o_wr_cmd_req: got %b, expected 1", $time, $sampled(o_wr_cmd_req));
        $display("Finished with errors");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (i_rst)
        (o_wr_cmd_req && i_wr_cmd_ack) |=> !o_wr_cmd_req)
    else begin
        $display("[ERROR] %0t o_wr_cmd_req: got %b, expected 0", $time, $sampled(o_wr_cmd_req));
        $display("Finished with errors");
        $fatal(1);
    end

    // Each loss pulse raises the interrupt in the same cycle
    assert property (@(posedge clk) disable iff (i_rst)
        (o_link_loss || o_sync_loss) |-> o_loss_interrupt)
    else begin
        $display("[ERROR] %0t o_loss_interrupt: got %b, expected 1",
                 $time, $sampled(o_loss_interrupt));
        $display("Finished with errors");
        $fatal(1);
    end

    // Loss outputs are single-cycle pulses
    assert property (@(posedge clk) disable iff (i_rst)
        (o_link_loss || o_sync_loss) |=> !(o_link_loss || o_sync_loss))
    else begin
        $display("[ERROR] %0t o_link_loss/o_sync_loss: got %b/%b, expected 0/0",
                 $time, $sampled(o_link_loss), $sampled(o_sync_loss));
        $display("Finished with errors");
        $fatal(1);
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    task automatic check_field(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual == expected)
        else begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // One line word per clock driven just after the edge
    task automatic send_word(input logic kmsb, input logic klsb, input logic [15:0] data);
        @(posedge clk);
        #2;
        i_2711_rkmsb = kmsb;
        i_2711_rklsb = klsb;
        i_2711_rxd   = data;
    endtask

    task automatic send_idle(input int n);
        repeat (n) send_word(1'b0, 1'b0, 16'h0000);
    endtask

    task automatic send_frame(input logic [15:0] len, input logic fe, input logic [1:0] ch,
                              input logic [3:0] dt, input logic [23:0] fnum,
                              input logic bad_sum, input int k_idx);
        logic [15:0] pay [0:63];
        logic [15:0] type_word;
        logic [15:0] sum;
        logic [63:0] packed_word;
        int          nwords;
        int          i;
        int          j;
        nwords    = int'(len) / 2;
        type_word = {fe, fe, ch, dt, fnum[23:16]};
        sum       = type_word + fnum[15:0] + len;
        for (i = 0; i < nwords; i++) begin
            pay[i] = 16'($random(seed));
            sum    = sum + pay[i];
        end
        // First word of a group goes in the top lane and zeros follow the last word
        for (i = 0; i < nwords; i = i + 4) begin
            packed_word = '0;
            for (j = 0; j < 4; j++) begin
                if (i + j < nwords) begin
                    packed_word[63-16*j -: 16] = pay[i+j];
                end
            end
            exp_dma[exp_wr] = packed_word;
            exp_wr          = exp_wr + 1;
        end
        exp_len = DLEN_WIDTH'((int'(len) + 7) / 8 * 8);

        // Sync {D5.6, K28.5} then start of frame {K28.2, K27.7}
        send_word(1'b0, 1'b1, 16'hC5BC);
        send_word(1'b1, 1'b1, 16'h5CFB);
        send_word(1'b0, 1'b0, 16'hEB90);
        send_word(1'b0, 1'b0, 16'hE116);
        send_word(1'b0, 1'b0, type_word);
        send_word(1'b0, 1'b0, fnum[15:0]);
        send_word(1'b0, 1'b0, len);
        for (i = 0; i < nwords; i++) begin
            send_word(i == k_idx, 1'b0, pay[i]);
        end
        send_word(1'b0, 1'b0, bad_sum ? sum + 16'd1 : sum);
        send_idle(3);

        check_field("o_rx_file_end_flag", 64'(o_rx_file_end_flag), 64'(fe));
        check_field("o_rx_channel_id", 64'(o_rx_channel_id), 64'(ch));
        check_field("o_rx_data_type", 64'(o_rx_data_type), 64'(dt));
        check_field("o_rx_frame_num", 64'(o_rx_frame_num), 64'(fnum));
        check_field("o_rx_frame_length", 64'(o_rx_frame_length), 64'(len));
        check_field("o_rx_checksum_flag", 64'(o_rx_checksum_flag), 64'(bad_sum));
        exp_addr    = exp_addr + ADDR_WIDTH'(exp_len);
        frames_sent = frames_sent + 1;
    endtask

    task automatic wait_dma_drain();
        while (exp_rd != exp_wr) begin
            @(posedge clk);
            #2;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        clk                    = 1'b0;
        i_rst                  = 1'b1;
        i_2711_rkmsb           = 1'b0;
        i_2711_rklsb           = 1'b0;
        i_2711_rxd             = 16'h0000;
        i_rx_start             = 1'b0;
        i_rx_base_addr         = '0;
        i_wr_cmd_ack           = 1'b0;
        i_dma_wr_ready         = 1'b1;
        i_link_loss_detect_ena = 1'b1;
        i_sync_loss_detect_ena = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        i_rst = 1'b0;

        check_field("o_wr_cmd_req", 64'(o_wr_cmd_req), 64'd0);
        check_field("o_dma_wr_valid", 64'(o_dma_wr_valid), 64'd0);
        check_field("o_link_loss", 64'(o_link_loss), 64'd0);
        check_field("o_sync_loss", 64'(o_sync_loss), 64'd0);
        check_field("o_loss_interrupt", 64'(o_loss_interrupt), 64'd0);
        send_idle(2);

        // Full groups and then the same with the DMA port stalled
        send_frame(16'd16, 1'b1, 2'd2, 4'd5, 24'h123456, 1'b0, -1);
        wait_dma_drain();
        i_dma_wr_ready = 1'b0;
        send_frame(16'd16, 1'b0, 2'd1, 4'd9, 24'hABCDEF, 1'b0, -1);
        send_idle(10);
        i_dma_wr_ready = 1'b1;
        wait_dma_drain();

        // Partial group padded with zeros and a count rounded to 16
        send_frame(16'd10, 1'b1, 2'd3, 4'd12, 24'h000102, 1'b0, -1);
        wait_dma_drain();

        // Checksum off by one and then a good frame that clears the flag
        send_frame(16'd8, 1'b0, 2'd0, 4'd3, 24'h7F0011, 1'b1, -1);
        send_frame(16'd12, 1'b1, 2'd1, 4'd6, 24'h7F0012, 1'b0, -1);
        wait_dma_drain();

        // New base address and two frames back to back in memory
        i_rx_base_addr = 32'h8000_1000;
        i_rx_start     = 1'b1;
        exp_addr       = 32'h8000_1000;
        send_idle(1);
        i_rx_start = 1'b0;
        send_frame(16'd10, 1'b0, 2'd2, 4'd1, 24'h000200, 1'b0, -1);
        send_frame(16'd16, 1'b0, 2'd2, 4'd1, 24'h000201, 1'b0, -1);
        wait_dma_drain();

        // K flag on a payload word and then on an idle word
        send_frame(16'd12, 1'b0, 2'd0, 4'd4, 24'h000300, 1'b0, 2);
        check_field("sync loss pulses", 64'(sync_pulses), 64'd1);
        check_field("loss interrupt pulses", 64'(intr_pulses), 64'd1);
        send_idle(45);
        send_word(1'b1, 1'b0, 16'h1234);
        send_idle(3);
        check_field("sync loss pulses", 64'(sync_pulses), 64'd1);
        check_field("loss interrupt pulses", 64'(intr_pulses), 64'd1);

        // Link down for 60 cycles spans one holdoff period
        repeat (60) send_word(1'b1, 1'b1, 16'hFFFF);
        send_idle(4);
        check_field("link loss pulses", 64'(link_pulses), 64'd2);
        check_field("loss interrupt pulses", 64'(intr_pulses), 64'd3);
        i_link_loss_detect_ena = 1'b0;
        repeat (60) send_word(1'b1, 1'b1, 16'hFFFF);
        send_idle(4);
        check_field("link loss pulses", 64'(link_pulses), 64'd2);
        check_field("loss interrupt pulses", 64'(intr_pulses), 64'd3);
        i_link_loss_detect_ena = 1'b1;

        wait_dma_drain();
        send_idle(2);
        if (ack_count == frames_sent) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Run ended with fewer command acks than frames sent");
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
design/rx_link_pkg.sv
design/rx_frame_if.sv
design/rx_frame_parser.sv
design/rx_word_packer.sv
design/dma_cmd_gen.sv
design/loss_holdoff.sv
design/tlk2711_rx_top.sv
verif/tb_rx_link.sv
